/* hdl/decode_config.svh */
/*
 * Decode stage configuration.
 * Widths of the instruction fields and data words, the link register,
 * the return-address offset and the reserved-instruction exception code.
 */
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5
`define IMM_WIDTH       16
`define SHAMT_WIDTH     5

// JAL links into $ra, return address skips the delay slot
`define LINK_REG        31
`define LINK_OFFSET     8

`define EXC_RI          10
`define EXC_WIDTH       5

`endif

/* hdl/decodePkg.sv */
/*
 * Decode stage types.
 * Vector types for words, register numbers, immediates, shift amounts and
 * exception codes, plus the instruction symbol and function group enums.
 */
`default_nettype none
`include "decode_config.svh"

package decodePkg;

    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [`IMM_WIDTH-1:0]      imm_t;
    typedef logic [`SHAMT_WIDTH-1:0]    shamt_t;
    // zero means no exception
    typedef logic [`EXC_WIDTH-1:0]      exc_t;

    typedef enum logic [5:0] {
        NOP = 6'd0,
        ADD, ADDU, SUB, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU, SLL, SRL,
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI,
        LW, SW,
        BEQ, BNE, BLEZ, BGTZ,
        J, JAL, JR, JALR
    } instr_e;

    // ALU_R first so a cleared register reads as a plain NOP
    typedef enum logic [2:0] {
        ALU_R = 3'd0,
        ALU_I,
        MEM_R,
        MEM_W,
        BRANCH,
        JUMP,
        OTHER
    } ifunc_e;

endpackage

`default_nettype wire

/* hdl/decodeIf.sv */
/*
 * Decode stage internal buses.
 * decodedIf carries the split instruction fields from the decoder,
 * preparedIf carries the prepared operands into the E-stage register.
 */
`timescale 1ns/100ps
`default_nettype none

interface decodedIf;
    import decodePkg::*;

    instr_e     instr;
    ifunc_e     ifunc;
    regAddr_t   rs;
    regAddr_t   rt;
    regAddr_t   rd;
    imm_t       imm;
    shamt_t     shamt;
    // target field of J and JAL
    logic [25:0] jmpAddr;
    exc_t       exc;

    modport decoder (output instr, ifunc, rs, rt, rd, imm, shamt, jmpAddr, exc);
    modport prep (input instr, ifunc, rs, rt, rd, imm, shamt, jmpAddr, exc);
endinterface

interface preparedIf;
    import decodePkg::*;

    instr_e     instr;
    ifunc_e     ifunc;
    exc_t       exc;
    regAddr_t   rs;
    regAddr_t   rt;
    logic       useRs;
    logic       useRt;
    word_t      dataRs;
    word_t      dataRt;
    word_t      extImm;
    word_t      extShamt;
    logic       regWEn;
    regAddr_t   regWAddr;
    word_t      regWData;
    logic       regWValid;

    modport prep (
        output instr, ifunc, exc, rs, rt, useRs, useRt, dataRs, dataRt,
               extImm, extShamt, regWEn, regWAddr, regWData, regWValid
    );
    modport stage (
        input instr, ifunc, exc, rs, rt, useRs, useRt, dataRs, dataRt,
              extImm, extShamt, regWEn, regWAddr, regWData, regWValid
    );
endinterface

`default_nettype wire

/* hdl/instrDecoder.sv */
/*
 * Instruction decoder.
 * Splits the instruction word into its fields, finds the instruction
 * symbol and its function group, and flags reserved codes as RI.
 */
`timescale 1ns/100ps
`default_nettype none
`include "decode_config.svh"

module instrDecoder (
    input  decodePkg::word_t code,
    decodedIf.decoder        dec
);
    import decodePkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    instr_e     rSym;
    instr_e     ijSym;
    instr_e     sym;
    ifunc_e     group;

    assign opcode = code[31:26];
    assign funct  = code[5:0];

    assign dec.rs      = code[25:21];
    assign dec.rt      = code[20:16];
    assign dec.rd      = code[15:11];
    assign dec.shamt   = code[10:6];
    assign dec.imm     = code[15:0];
    assign dec.jmpAddr = code[25:0];

    // SPECIAL opcode, symbol from funct
    always_comb begin
        case (funct)
            6'b100000: rSym = ADD;
            6'b100001: rSym = ADDU;
            6'b100010: rSym = SUB;
            6'b100011: rSym = SUBU;
            6'b100100: rSym = AND;
            6'b100101: rSym = OR;
            6'b100110: rSym = XOR;
            6'b100111: rSym = NOR;
            6'b101010: rSym = SLT;
            6'b101011: rSym = SLTU;
            6'b000000: rSym = SLL;
            6'b000010: rSym = SRL;
            6'b001000: rSym = JR;
            6'b001001: rSym = JALR;
            default:   rSym = NOP;
        endcase
    end

    // I and J formats, symbol from opcode
    always_comb begin
        case (opcode)
            6'b001000: ijSym = ADDI;
            6'b001001: ijSym = ADDIU;
            6'b001100: ijSym = ANDI;
            6'b001101: ijSym = ORI;
            6'b001110: ijSym = XORI;
            6'b001111: ijSym = LUI;
            6'b001010: ijSym = SLTI;
            6'b100011: ijSym = LW;
            6'b101011: ijSym = SW;
            6'b000100: ijSym = BEQ;
            6'b000101: ijSym = BNE;
            6'b000110: ijSym = BLEZ;
            6'b000111: ijSym = BGTZ;
            6'b000010: ijSym = J;
            6'b000011: ijSym = JAL;
            default:   ijSym = NOP;
        endcase
    end

    // all-zero word is the canonical NOP, not SLL
    assign sym = (code == '0)         ? NOP  :
                 (opcode == 6'b000000) ? rSym :
                 ijSym;

    assign dec.instr = sym;

    // any other code that maps to NOP is reserved
    assign dec.exc = (code != '0 && sym == NOP) ? exc_t'(`EXC_RI) : '0;

    always_comb begin
        case (sym)
            NOP, ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR,
            SLT, SLTU, SLL, SRL:                   group = ALU_R;
            ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI: group = ALU_I;
            LW:                                    group = MEM_R;
            SW:                                    group = MEM_W;
            BEQ, BNE, BLEZ, BGTZ:                  group = BRANCH;
            J, JAL, JR, JALR:                      group = JUMP;
            default:                               group = OTHER;
        endcase
    end

    assign dec.ifunc = group;

endmodule

`default_nettype wire

/* hdl/operandPrep.sv */
/*
 * Operand preparation.
 * Selects register operands through the E and M bypass, compares them
 * for branches, extends the immediate and works out the register write.
 */
`timescale 1ns/100ps
`default_nettype none
`include "decode_config.svh"

module operandPrep (
    decodedIf.prep              dec,
    preparedIf.prep             prep,
    input  decodePkg::word_t    pc,
    input  decodePkg::exc_t     excIn,
    input  decodePkg::word_t    dataRsD,
    input  decodePkg::word_t    dataRtD,
    input  logic                regWEnE,
    input  decodePkg::regAddr_t regWAddrE,
    input  decodePkg::word_t    regWDataE,
    input  logic                regWEnM,
    input  decodePkg::regAddr_t regWAddrM,
    input  decodePkg::word_t    regWDataM,
    output logic                cmp,
    output decodePkg::word_t    jmpReg
);
    import decodePkg::*;

    word_t dataRs;
    word_t dataRt;
    word_t signExt;
    word_t zeroExt;
    word_t luiExt;

    // E is younger than M, so it wins; $zero is never forwarded
    function automatic word_t bypass(input regAddr_t addr, input word_t fileData);
        if (regWEnE && regWAddrE == addr && regWAddrE != '0) begin
            return regWDataE;
        end
        if (regWEnM && regWAddrM == addr && regWAddrM != '0) begin
            return regWDataM;
        end
        return fileData;
    endfunction

    always_comb begin
        dataRs = bypass(dec.rs, dataRsD);
        dataRt = bypass(dec.rt, dataRtD);
    end

    assign jmpReg = dataRs;

    always_comb begin
        case (dec.instr)
            BEQ:     cmp = (dataRs == dataRt);
            BNE:     cmp = (dataRs != dataRt);
            BLEZ:    cmp = ($signed(dataRs) <= 0);
            BGTZ:    cmp = ($signed(dataRs) > 0);
            default: cmp = 1'b0;
        endcase
    end

    assign signExt = {{(`WORD_WIDTH-`IMM_WIDTH){dec.imm[`IMM_WIDTH-1]}}, dec.imm};
    assign zeroExt = word_t'(dec.imm);
    assign luiExt  = {dec.imm, {(`WORD_WIDTH-`IMM_WIDTH){1'b0}}};

    always_comb begin
        case (dec.instr)
            ANDI, ORI, XORI: prep.extImm = zeroExt;
            LUI:             prep.extImm = luiExt;
            default:         prep.extImm = signExt;
        endcase
    end

    assign prep.extShamt = word_t'(dec.shamt);

    always_comb begin
        prep.regWEn   = 1'b0;
        prep.regWAddr = '0;
        if ((dec.ifunc == ALU_R && dec.instr != NOP) || dec.instr == JALR) begin
            prep.regWEn   = 1'b1;
            prep.regWAddr = dec.rd;
        end else if (dec.ifunc == ALU_I || dec.instr == LW) begin
            prep.regWEn   = 1'b1;
            prep.regWAddr = dec.rt;
        end else if (dec.instr == JAL) begin
            prep.regWEn   = 1'b1;
            prep.regWAddr = regAddr_t'(`LINK_REG);
        end
    end

    // results already known in D
    assign prep.regWData  = (dec.instr == JAL || dec.instr == JALR) ? pc + word_t'(`LINK_OFFSET) :
                            (dec.instr == LUI) ? luiExt :
                            '0;
    assign prep.regWValid = (dec.instr == JAL || dec.instr == LUI);

    assign prep.useRs = !(dec.instr inside {SLL, SRL, LUI, J});
    assign prep.useRt = !(dec.ifunc == ALU_I || dec.ifunc == JUMP ||
                          dec.instr inside {LW, BLEZ, BGTZ});

    // an exception from fetch takes priority
    assign prep.exc      = (excIn != '0) ? excIn : dec.exc;
    assign prep.instr    = dec.instr;
    assign prep.ifunc    = dec.ifunc;
    assign prep.rs       = dec.rs;
    assign prep.rt       = dec.rt;
    assign prep.dataRs   = dataRs;
    assign prep.dataRt   = dataRt;

endmodule

`default_nettype wire

/* hdl/execRegister.sv */
/*
 * D-to-E pipeline register.
 * Stall holds the contents, clear without stall inserts a NOP bubble.
 */
`timescale 1ns/100ps
`default_nettype none

module execRegister (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                clear,
    preparedIf.stage            prep,
    input  decodePkg::word_t    pcD,
    output decodePkg::instr_e   instrE,
    output decodePkg::ifunc_e   ifuncE,
    output decodePkg::word_t    pcE,
    output decodePkg::exc_t     excE,
    output decodePkg::regAddr_t addrRsE,
    output decodePkg::regAddr_t addrRtE,
    output logic                useRsE,
    output logic                useRtE,
    output decodePkg::word_t    dataRsE,
    output decodePkg::word_t    dataRtE,
    output decodePkg::word_t    extImmE,
    output decodePkg::word_t    extShamtE,
    output logic                regWEnE,
    output decodePkg::regAddr_t regWAddrE,
    output decodePkg::word_t    regWDataE,
    output logic                regWValidE
);
    import decodePkg::*;

    // clear during stall is ignored, the held instruction stays
    always_ff @(posedge clk) begin
        if (reset || (clear && !stall)) begin
            instrE     <= NOP;
            ifuncE     <= ALU_R;
            pcE        <= '0;
            excE       <= '0;
            addrRsE    <= '0;
            addrRtE    <= '0;
            useRsE     <= 1'b0;
            useRtE     <= 1'b0;
            dataRsE    <= '0;
            dataRtE    <= '0;
            extImmE    <= '0;
            extShamtE  <= '0;
            regWEnE    <= 1'b0;
            regWAddrE  <= '0;
            regWDataE  <= '0;
            regWValidE <= 1'b0;
        end else if (!stall) begin
            instrE     <= prep.instr;
            ifuncE     <= prep.ifunc;
            pcE        <= pcD;
            excE       <= prep.exc;
            addrRsE    <= prep.rs;
            addrRtE    <= prep.rt;
            useRsE     <= prep.useRs;
            useRtE     <= prep.useRt;
            // bypassed values, not the raw file read
            dataRsE    <= prep.dataRs;
            dataRtE    <= prep.dataRt;
            extImmE    <= prep.extImm;
            extShamtE  <= prep.extShamt;
            regWEnE    <= prep.regWEn;
            regWAddrE  <= prep.regWAddr;
            regWDataE  <= prep.regWData;
            regWValidE <= prep.regWValid;
        end
    end

endmodule

`default_nettype wire

/* hdl/decodeStage.sv */
/*
 * Decode stage of the five-stage pipeline.
 * Decoder, operand preparation and the D-to-E register,
 * with the E-stage write fed back for bypassing.
 */
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
    input  logic                clk,
    input  logic                reset,
    input  decodePkg::word_t    code,
    input  decodePkg::word_t    pc,
    input  decodePkg::exc_t     excIn,
    input  decodePkg::word_t    dataRsD,
    input  decodePkg::word_t    dataRtD,
    input  logic                regWEnM,
    input  decodePkg::regAddr_t regWAddrM,
    input  decodePkg::word_t    regWDataM,
    input  logic                stall,
    input  logic                clear,
    output logic                cmp,
    output logic [25:0]         jmpAddr,
    output decodePkg::word_t    jmpReg,
    output decodePkg::regAddr_t addrRsD,
    output decodePkg::regAddr_t addrRtD,
    output decodePkg::instr_e   instrE,
    output decodePkg::ifunc_e   ifuncE,
    output decodePkg::word_t    pcE,
    output decodePkg::exc_t     excE,
    output decodePkg::regAddr_t addrRsE,
    output decodePkg::regAddr_t addrRtE,
    output logic                useRsE,
    output logic                useRtE,
    output decodePkg::word_t    dataRsE,
    output decodePkg::word_t    dataRtE,
    output decodePkg::word_t    extImmE,
    output decodePkg::word_t    extShamtE,
    output logic                regWEnE,
    output decodePkg::regAddr_t regWAddrE,
    output decodePkg::word_t    regWDataE,
    output logic                regWValidE
);
    decodedIf  decoded ();
    preparedIf prepared ();

    // register numbers go to the file read ports
    assign addrRsD = decoded.rs;
    assign addrRtD = decoded.rt;
    assign jmpAddr = decoded.jmpAddr;

    instrDecoder u_instrDecoder (
        .code (code),
        .dec  (decoded.decoder)
    );

    operandPrep u_operandPrep (
        .dec       (decoded.prep),
        .prep      (prepared.prep),
        .pc        (pc),
        .excIn     (excIn),
        .dataRsD   (dataRsD),
        .dataRtD   (dataRtD),
        .regWEnE   (regWEnE),
        .regWAddrE (regWAddrE),
        .regWDataE (regWDataE),
        .regWEnM   (regWEnM),
        .regWAddrM (regWAddrM),
        .regWDataM (regWDataM),
        .cmp       (cmp),
        .jmpReg    (jmpReg)
    );

    execRegister u_execRegister (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .clear      (clear),
        .prep       (prepared.stage),
        .pcD        (pc),
        .instrE     (instrE),
        .ifuncE     (ifuncE),
        .pcE        (pcE),
        .excE       (excE),
        .addrRsE    (addrRsE),
        .addrRtE    (addrRtE),
        .useRsE     (useRsE),
        .useRtE     (useRtE),
        .dataRsE    (dataRsE),
        .dataRtE    (dataRtE),
        .extImmE    (extImmE),
        .extShamtE  (extShamtE),
        .regWEnE    (regWEnE),
        .regWAddrE  (regWAddrE),
        .regWDataE  (regWDataE),
        .regWValidE (regWValidE)
    );

endmodule

`default_nettype wire

/* bench/tbClock.sv */
/*
 * Testbench clock and reset.
 * 10 ns clock, reset held high for the first three rising edges.
 */
`timescale 1ns/100ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic reset
);
    localparam int RESET_CYCLES = 3;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
    end

    always #5 clk = ~clk;

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* bench/decodeStage_asserts.sv */
/*
 * Assertions on the decode stage E register.
 * Reset clears the write flags, stall holds the register,
 * a disabled write carries register zero.
 */
`timescale 1ns/100ps
`default_nettype none

module decodeStageAsserts (
    input wire logic        clk,
    input wire logic        reset,
    input wire logic        stall,
    input wire logic [5:0]  instrE,
    input wire logic [2:0]  ifuncE,
    input wire logic [31:0] pcE,
    input wire logic [4:0]  excE,
    input wire logic [4:0]  addrRsE,
    input wire logic [4:0]  addrRtE,
    input wire logic        useRsE,
    input wire logic        useRtE,
    input wire logic [31:0] dataRsE,
    input wire logic [31:0] dataRtE,
    input wire logic [31:0] extImmE,
    input wire logic [31:0] extShamtE,
    input wire logic        regWEnE,
    input wire logic [4:0]  regWAddrE,
    input wire logic [31:0] regWDataE,
    input wire logic        regWValidE
);
    logic [224:0] eState;

    assign eState = {instrE, ifuncE, pcE, excE, addrRsE, addrRtE, useRsE, useRtE,
                     dataRsE, dataRtE, extImmE, extShamtE,
                     regWEnE, regWAddrE, regWDataE, regWValidE};

    resetClearsWrite: assert property (@(posedge clk) reset |=> (!regWEnE && !regWValidE))
        else $error("write flags set after reset");

    stallHolds: assert property (@(posedge clk) (stall && !reset) |=> $stable(eState))
        else $error("E register changed during stall");

    // no write means no destination
    idleAddrZero: assert property (@(posedge clk) !regWEnE |-> (regWAddrE == 5'd0))
        else $error("regWAddrE nonzero without regWEnE");

endmodule

bind decodeStage decodeStageAsserts u_decodeStageAsserts (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .instrE     (instrE),
    .ifuncE     (ifuncE),
    .pcE        (pcE),
    .excE       (excE),
    .addrRsE    (addrRsE),
    .addrRtE    (addrRtE),
    .useRsE     (useRsE),
    .useRtE     (useRtE),
    .dataRsE    (dataRsE),
    .dataRtE    (dataRtE),
    .extImmE    (extImmE),
    .extShamtE  (extShamtE),
    .regWEnE    (regWEnE),
    .regWAddrE  (regWAddrE),
    .regWDataE  (regWDataE),
    .regWValidE (regWValidE)
);

`default_nettype wire

/* bench/decodeStageTb.sv */
/*
 * Testbench for the decode stage.
 * Reads one cycle per stimulus line, drives the DUT on the rising edge,
 * checks cmp in the same cycle and the E register one edge later.
 */
`timescale 1ns/100ps
`default_nettype none
`include "decode_config.svh"

module decodeStageTb;
    import decodePkg::*;

    localparam int MAX_LINES = 64;
    // stimulus columns after the test name
    localparam int C_CODE = 0, C_PC = 1, C_EXC = 2, C_RS = 3, C_RT = 4;
    localparam int C_WENM = 5, C_WADDRM = 6, C_WDATAM = 7, C_STALL = 8, C_CLEAR = 9;
    localparam int C_RND = 10, C_CMP = 11, C_INSTR = 12, C_IFUNC = 13, C_EXCE = 14;
    localparam int C_DRS = 15, C_DRT = 16, C_IMM = 17, C_WEN = 18, C_WADDR = 19;
    localparam int C_WDATA = 20, C_WVALID = 21;

    logic clk;
    logic reset;
    word_t code, pc, dataRsD, dataRtD, regWDataM;
    exc_t excIn;
    logic regWEnM, stall, clear;
    regAddr_t regWAddrM;
    logic cmp;
    logic [25:0] jmpAddr;
    word_t jmpReg;
    regAddr_t addrRsD, addrRtD;
    instr_e instrE;
    ifunc_e ifuncE;
    word_t pcE, dataRsE, dataRtE, extImmE, extShamtE, regWDataE;
    exc_t excE;
    regAddr_t addrRsE, addrRtE, regWAddrE;
    logic useRsE, useRtE, regWEnE, regWValidE;

    string names [0:MAX_LINES-1];
    logic [`WORD_WIDTH-1:0] fields [0:MAX_LINES-1][0:21];
    int lineCount = 0;
    int cycleLimit = 0;
    int cycles = 0;
    integer seed = 32'h5257;

    // model of the E fields missing from the stimulus file
    word_t expPcE = '0;
    word_t expShamtE = '0;
    regAddr_t expRsE = '0;
    regAddr_t expRtE = '0;
    logic expUseRs = 1'b1;
    logic expUseRt = 1'b1;

    tbClock u_tbClock (.clk(clk), .reset(reset));

    decodeStage u_decodeStage (.*);

    task automatic checkValue(input string testName, input string field,
                              input logic [`WORD_WIDTH-1:0] expected,
                              input logic [`WORD_WIDTH-1:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s expected %h actual %h", testName, field, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic loadStimulus();
        int fd;
        int r;
        string text;
        fd = $fopen("bench/decode_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            $display("TEST RESULT: FAIL");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd) && lineCount < MAX_LINES) begin
            text = "";
            r = $fgets(text, fd);
            if (r != 0 && text.len() > 1 && text.getc(0) != "#") begin
                r = $sscanf(text,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    names[lineCount], fields[lineCount][0], fields[lineCount][1],
                    fields[lineCount][2], fields[lineCount][3], fields[lineCount][4],
                    fields[lineCount][5], fields[lineCount][6], fields[lineCount][7],
                    fields[lineCount][8], fields[lineCount][9], fields[lineCount][10],
                    fields[lineCount][11], fields[lineCount][12], fields[lineCount][13],
                    fields[lineCount][14], fields[lineCount][15], fields[lineCount][16],
                    fields[lineCount][17], fields[lineCount][18], fields[lineCount][19],
                    fields[lineCount][20], fields[lineCount][21]);
                if (r == 23) begin
                    lineCount++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic driveLine(input int i);
        word_t rsVal;
        word_t rtVal;
        rsVal = fields[i][C_RS];
        rtVal = fields[i][C_RT];
        // idle lines get random file data, which then shows up in E
        if (fields[i][C_RND] != 0) begin
            rsVal = $random(seed);
            rtVal = $random(seed);
            fields[i][C_RS] = rsVal;
            fields[i][C_RT] = rtVal;
            fields[i][C_DRS] = rsVal;
            fields[i][C_DRT] = rtVal;
        end
        code      <= fields[i][C_CODE];
        pc        <= fields[i][C_PC];
        excIn     <= exc_t'(fields[i][C_EXC]);
        dataRsD   <= rsVal;
        dataRtD   <= rtVal;
        regWEnM   <= fields[i][C_WENM][0];
        regWAddrM <= regAddr_t'(fields[i][C_WADDRM]);
        regWDataM <= fields[i][C_WDATAM];
        stall     <= fields[i][C_STALL][0];
        clear     <= fields[i][C_CLEAR][0];
    endtask

    // rs operand by the bypass rule, E write taken from the previous line
    function automatic word_t expectedRs(input int i);
        regAddr_t rs;
        rs = fields[i][C_CODE][25:21];
        if (i > 0 && fields[i-1][C_WEN][0] && fields[i-1][C_WADDR] == rs && rs != 0) begin
            return fields[i-1][C_WDATA];
        end
        if (fields[i][C_WENM][0] && fields[i][C_WADDRM] == rs && rs != 0) begin
            return fields[i][C_WDATAM];
        end
        return fields[i][C_RS];
    endfunction

    task automatic checkDecode(input int i);
        word_t lineCode;
        lineCode = fields[i][C_CODE];
        checkValue(names[i], "cmp", fields[i][C_CMP], cmp);
        checkValue(names[i], "jmpAddr", lineCode[25:0], jmpAddr);
        checkValue(names[i], "addrRsD", lineCode[25:21], addrRsD);
        checkValue(names[i], "addrRtD", lineCode[20:16], addrRtD);
        checkValue(names[i], "jmpReg", expectedRs(i), jmpReg);
    endtask

    task automatic predictExec(input int i);
        word_t lineCode;
        instr_e sym;
        lineCode = fields[i][C_CODE];
        sym = instr_e'(fields[i][C_INSTR][5:0]);
        if (!fields[i][C_STALL][0] && fields[i][C_CLEAR][0]) begin
            expPcE    = '0;
            expRsE    = '0;
            expRtE    = '0;
            expShamtE = '0;
            expUseRs  = 1'b0;
            expUseRt  = 1'b0;
        end else if (!fields[i][C_STALL][0]) begin
            expPcE    = fields[i][C_PC];
            expRsE    = lineCode[25:21];
            expRtE    = lineCode[20:16];
            expShamtE = word_t'(lineCode[10:6]);
            expUseRs  = !(sym inside {SLL, SRL, LUI, J});
            expUseRt  = !(sym inside {ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, LW,
                                      BLEZ, BGTZ, J, JAL, JR, JALR});
        end
    endtask

    task automatic checkExec(input int i);
        predictExec(i);
        checkValue(names[i], "instrE", fields[i][C_INSTR], instrE);
        checkValue(names[i], "ifuncE", fields[i][C_IFUNC], ifuncE);
        checkValue(names[i], "excE", fields[i][C_EXCE], excE);
        checkValue(names[i], "dataRsE", fields[i][C_DRS], dataRsE);
        checkValue(names[i], "dataRtE", fields[i][C_DRT], dataRtE);
        checkValue(names[i], "extImmE", fields[i][C_IMM], extImmE);
        checkValue(names[i], "regWEnE", fields[i][C_WEN], regWEnE);
        checkValue(names[i], "regWAddrE", fields[i][C_WADDR], regWAddrE);
        checkValue(names[i], "regWDataE", fields[i][C_WDATA], regWDataE);
        checkValue(names[i], "regWValidE", fields[i][C_WVALID], regWValidE);
        checkValue(names[i], "pcE", expPcE, pcE);
        checkValue(names[i], "addrRsE", expRsE, addrRsE);
        checkValue(names[i], "addrRtE", expRtE, addrRtE);
        checkValue(names[i], "useRsE", expUseRs, useRsE);
        checkValue(names[i], "useRtE", expUseRt, useRtE);
        checkValue(names[i], "extShamtE", expShamtE, extShamtE);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit != 0 && cycles >= cycleLimit) begin
            $display("run did not finish within %0d cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        code = '0;
        pc = '0;
        excIn = '0;
        dataRsD = '0;
        dataRtD = '0;
        regWEnM = 1'b0;
        regWAddrM = '0;
        regWDataM = '0;
        stall = 1'b0;
        clear = 1'b0;
        loadStimulus();
        cycleLimit = lineCount + 20;
        wait (reset == 1'b0);
        for (int i = 0; i < lineCount; i++) begin
            @(posedge clk);
            driveLine(i);
            @(negedge clk);
            checkDecode(i);
            if (i > 0) begin
                checkExec(i - 1);
            end
        end
        @(posedge clk);
        @(negedge clk);
        checkExec(lineCount - 1);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* decodeStage.f */
+incdir+hdl
hdl/decodePkg.sv
hdl/decodeIf.sv
hdl/instrDecoder.sv
hdl/operandPrep.sv
hdl/execRegister.sv
hdl/decodeStage.sv
bench/tbClock.sv
bench/decodeStage_asserts.sv
bench/decodeStageTb.sv

/* Bender.yml */
package:
  name: decodeStage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/decodePkg.sv
      - hdl/decodeIf.sv
      - hdl/instrDecoder.sv
      - hdl/operandPrep.sv
      - hdl/execRegister.sv
      - hdl/decodeStage.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - bench/tbClock.sv
      - bench/decodeStage_asserts.sv
      - bench/decodeStageTb.sv

/* bench/decode_stimulus.txt */
# name code pc excIn rsD rtD wEnM wAddrM wDataM stall clear rnd | cmp
#   then E after the edge: instr ifunc exc dataRs dataRt extImm wEn wAddr wData wValid
add 00221820 100 0 11 22 0 0 0 0 0 0 0 01 0 0 11 22 00001820 1 3 0 0
addu 00221821 100 0 11 22 0 0 0 0 0 0 0 02 0 0 11 22 00001821 1 3 0 0
sub 00221822 100 0 11 22 0 0 0 0 0 0 0 03 0 0 11 22 00001822 1 3 0 0
subu 00221823 100 0 11 22 0 0 0 0 0 0 0 04 0 0 11 22 00001823 1 3 0 0
and 00221824 100 0 11 22 0 0 0 0 0 0 0 05 0 0 11 22 00001824 1 3 0 0
or 00221825 100 0 11 22 0 0 0 0 0 0 0 06 0 0 11 22 00001825 1 3 0 0
xor 00221826 100 0 11 22 0 0 0 0 0 0 0 07 0 0 11 22 00001826 1 3 0 0
nor 00221827 100 0 11 22 0 0 0 0 0 0 0 08 0 0 11 22 00001827 1 3 0 0
slt 0022182a 100 0 11 22 0 0 0 0 0 0 0 09 0 0 11 22 0000182a 1 3 0 0
sltu 0022182b 100 0 11 22 0 0 0 0 0 0 0 0a 0 0 11 22 0000182b 1 3 0 0
sll 00221840 100 0 11 22 0 0 0 0 0 0 0 0b 0 0 11 22 00001840 1 3 0 0
srl 00221842 100 0 11 22 0 0 0 0 0 0 0 0c 0 0 11 22 00001842 1 3 0 0
addi 20248000 100 0 11 0 0 0 0 0 0 0 0 0d 1 0 11 0 ffff8000 1 4 0 0
addiu 24240005 100 0 11 0 0 0 0 0 0 0 0 0e 1 0 11 0 00000005 1 4 0 0
andi 30248000 100 0 11 0 0 0 0 0 0 0 0 0f 1 0 11 0 00008000 1 4 0 0
ori 34248001 100 0 11 0 0 0 0 0 0 0 0 10 1 0 11 0 00008001 1 4 0 0
xori 3824ffff 100 0 11 0 0 0 0 0 0 0 0 11 1 0 11 0 0000ffff 1 4 0 0
slti 2824ffff 100 0 11 0 0 0 0 0 0 0 0 13 1 0 11 0 ffffffff 1 4 0 0
lui 3c241234 100 0 11 0 0 0 0 0 0 0 0 12 1 0 11 0 12340000 1 4 12340000 1
lw 8c240010 100 0 11 0 0 0 0 0 0 0 0 14 2 0 11 12340000 00000010 1 4 0 0
sw ac240010 100 0 11 22 0 0 0 0 0 0 0 15 3 0 11 0 00000010 0 0 0 0
beqEq 10220003 100 0 55 55 0 0 0 0 0 0 1 16 4 0 55 55 00000003 0 0 0 0
beqNe 10220003 100 0 55 56 0 0 0 0 0 0 0 16 4 0 55 56 00000003 0 0 0 0
bne 14220003 100 0 55 56 0 0 0 0 0 0 1 17 4 0 55 56 00000003 0 0 0 0
blezNeg 18220003 100 0 ffffffff 22 0 0 0 0 0 0 1 18 4 0 ffffffff 22 00000003 0 0 0 0
blezZero 18220003 100 0 0 22 0 0 0 0 0 0 1 18 4 0 0 22 00000003 0 0 0 0
bgtzPos 1c220003 100 0 7fffffff 22 0 0 0 0 0 0 1 19 4 0 7fffffff 22 00000003 0 0 0 0
bgtzNeg 1c220003 100 0 80000000 22 0 0 0 0 0 0 0 19 4 0 80000000 22 00000003 0 0 0 0
j 08000040 100 0 11 22 0 0 0 0 0 0 0 1a 5 0 11 22 00000040 0 0 0 0
jal 0c000040 200 0 11 22 0 0 0 0 0 0 0 1b 5 0 11 22 00000040 1 1f 208 1
jr 00200008 100 0 11 22 0 0 0 0 0 0 0 1c 5 0 11 22 00000008 0 0 0 0
jalr 0020f809 300 0 11 22 0 0 0 0 0 0 0 1d 5 0 11 22 fffff809 1 1f 308 0
reserved fc000000 100 0 11 22 0 0 0 0 0 0 0 00 0 0a 11 22 00000000 0 0 0 0
excIn 00221820 100 5 11 22 0 0 0 0 0 0 0 01 0 05 11 22 00001820 1 3 0 0
idleA 00000000 100 0 0 0 0 0 0 0 0 1 0 00 0 0 0 0 00000000 0 0 0 0
luiR1 3c0100aa 100 0 0 0 0 0 0 0 0 0 0 12 1 0 0 0 00aa0000 1 1 00aa0000 1
bypassE 10220003 100 0 11 00aa0000 1 1 77 0 0 0 1 16 4 0 00aa0000 00aa0000 00000003 0 0 0 0
bypassM 10220003 100 0 11 99 1 2 11 0 0 0 1 16 4 0 11 11 00000003 0 0 0 0
regZero 10020003 100 0 66 66 1 0 55 0 0 0 1 16 4 0 66 66 00000003 0 0 0 0
load 00221820 100 0 11 22 0 0 0 0 0 0 0 01 0 0 11 22 00001820 1 3 0 0
stall 00221822 100 0 33 22 0 0 0 1 0 0 0 01 0 0 11 22 00001820 1 3 0 0
stallClr 00221822 100 0 33 22 0 0 0 1 1 0 0 01 0 0 11 22 00001820 1 3 0 0
clear 00221822 100 0 33 22 0 0 0 0 1 0 0 00 0 0 0 0 00000000 0 0 0 0
idleB 00000000 100 0 0 0 0 0 0 0 0 1 0 00 0 0 0 0 00000000 0 0 0 0
